// ==== verilog/ob_pkg.sv ====
// **************************************
// Shared types and constants for the ask-side order table
// Widths, depth, slot layout and the mask helpers used by the
// table core and the query walker
// **************************************
`default_nettype none

package ob_pkg;

  // Live entries; slot TABLE_DEPTH is the head, slot 0 the reject
  localparam int TABLE_DEPTH = 8;

  typedef logic [15:0] price_t;
  typedef logic [7:0]  quantity_t;
  // Holds the sum of a full table of quantities
  typedef logic [11:0] accum_qty_t;
  typedef logic [7:0]  uid_t;

  // Empty slot marker, sorts behind every real ask price
  localparam price_t PRICE_INVALID = '1;

  typedef struct packed {
    uid_t      uid;
    quantity_t quantity;
    price_t    price;
  } entry_t;

  localparam entry_t ENTRY_EMPTY = '{uid: '0, quantity: '0, price: PRICE_INVALID};

  typedef entry_t [TABLE_DEPTH:0]             table_t;
  typedef logic [TABLE_DEPTH:0]               slot_vec_t;
  typedef logic [$clog2(TABLE_DEPTH+1)-1:0]   slot_idx_t;

  // One-hot of the set bit nearest the head
  function automatic slot_vec_t pick_nearest_head(slot_vec_t x);
    slot_vec_t r;
    r = '0;
    for (int i = 0; i <= TABLE_DEPTH; i++) begin
      if (x[i]) begin
        r    = '0;
        r[i] = 1'b1;
      end
    end
    return r;
  endfunction

  // Unary mask from the one-hot position down to slot 0
  function automatic slot_vec_t mask_below(slot_vec_t onehot, logic inclusive);
    slot_vec_t r;
    logic      seen;
    seen = 1'b0;
    for (int i = TABLE_DEPTH; i >= 0; i--) begin
      r[i] = (inclusive && onehot[i]) || seen;
      seen = seen || onehot[i];
    end
    return r;
  endfunction

endpackage

`default_nettype wire

// ==== verilog/ob_table_core.sv ====
// **************************************
// Price-ordered shift table for the ask side
// Lowest price at the head slot, ties kept in arrival order
// Handles insert, cancel by uid, head pop and reject pop
// Table and valid vector are exported for the depth query
// **************************************
`timescale 1ns/1ps
`default_nettype none

module ob_table_core (
  input  logic              clk,
  input  logic              rst,
  input  logic              insert,
  input  ob_pkg::entry_t    insert_entry,
  input  logic              cancel,
  input  ob_pkg::uid_t      cancel_uid,
  input  logic              head_pop,
  input  logic              reject_pop,
  output logic              cancel_hit,
  output ob_pkg::entry_t    cancel_entry,
  output logic              head_vld,
  output ob_pkg::entry_t    head,
  output logic              reject_vld,
  output ob_pkg::entry_t    reject,
  output ob_pkg::table_t    tbl,
  output ob_pkg::slot_vec_t tbl_vld
);

  import ob_pkg::*;

  // Insert side
  slot_vec_t insert_match;
  slot_vec_t install;
  slot_vec_t shift_dn;

  // Cancel and pop side
  slot_vec_t cancel_match;
  slot_vec_t shift_up;

  // Neighbour sources for each slot
  table_t    up_src;
  table_t    dn_src;

  // Next state
  table_t    tbl_nxt;
  slot_vec_t tbl_vld_nxt;

  // Insert placement
  always_comb begin
    // Slots holding a strictly higher price
    // Equal price stays ahead, which keeps FIFO order among ties
    for (int i = 0; i <= TABLE_DEPTH; i++) begin
      insert_match[i] = insert && (insert_entry.price < tbl[i].price);
    end
    // New entry goes to the nearest-head slot that loses to it
    // Empty reject slot always matches, so a worst insert lands there
    install  = pick_nearest_head(insert_match);
    // Everything below the install point moves toward slot 0
    shift_dn = mask_below(install, 1'b0);
  end

  // Cancel lookup
  always_comb begin
    // Uid compare over live slots only
    for (int i = 0; i <= TABLE_DEPTH; i++) begin
      cancel_match[i] = cancel && tbl_vld[i] && (tbl[i].uid == cancel_uid);
    end
    cancel_hit = |cancel_match;

    // Hit entry out, zero when nothing matched
    cancel_entry = '0;
    for (int i = 0; i <= TABLE_DEPTH; i++) begin
      if (cancel_match[i]) begin
        cancel_entry = tbl[i];
      end
    end

    // Hit slot and all behind it close the gap
    // Head pop moves the whole table up
    shift_up = mask_below(cancel_match, 1'b1) | {(TABLE_DEPTH+1){head_pop}};
  end

  // Neighbour sources
  always_comb begin
    // Shift up pulls from the slot behind, reject slot refills empty
    up_src[0] = ENTRY_EMPTY;
    for (int i = 1; i <= TABLE_DEPTH; i++) begin
      up_src[i] = tbl[i-1];
    end
    // Shift down pulls from the slot ahead
    for (int i = 0; i < TABLE_DEPTH; i++) begin
      dn_src[i] = tbl[i+1];
    end
    // Head never shifts down
    dn_src[TABLE_DEPTH] = tbl[TABLE_DEPTH];
  end

  // Per-slot next state
  always_comb begin
    for (int i = 0; i <= TABLE_DEPTH; i++) begin
      if (install[i]) begin
        tbl_nxt[i] = insert_entry;
      end else if (shift_up[i]) begin
        tbl_nxt[i] = up_src[i];
      end else if (shift_dn[i]) begin
        tbl_nxt[i] = dn_src[i];
      end else if (reject_pop && (i == 0)) begin
        // Reject drained by the outside
        tbl_nxt[i] = ENTRY_EMPTY;
      end else begin
        tbl_nxt[i] = tbl[i];
      end
      // Slot is live when it carries a real price
      tbl_vld_nxt[i] = (tbl_nxt[i].price != PRICE_INVALID);
    end
  end

  // Table registers
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i <= TABLE_DEPTH; i++) begin
        tbl[i] <= ENTRY_EMPTY;
      end
      tbl_vld <= '0;
    end else begin
      tbl     <= tbl_nxt;
      tbl_vld <= tbl_vld_nxt;
    end
  end

  // Head and reject read straight from their slots
  assign head       = tbl[TABLE_DEPTH];
  assign head_vld   = (tbl[TABLE_DEPTH].price != PRICE_INVALID);
  assign reject     = tbl[0];
  assign reject_vld = (tbl[0].price != PRICE_INVALID);

  // Commands are mutually exclusive
  assert property (@(posedge clk) disable iff (rst)
    $onehot0({insert, cancel, head_pop, reject_pop}))
    else $error("more than one table command in a cycle");

  // A pending reject must be drained before the next insert
  assert property (@(posedge clk) disable iff (rst)
    insert |-> !reject_vld)
    else $error("insert while reject slot is occupied");

  // Uids are unique across the live slots
  assert property (@(posedge clk) disable iff (rst)
    cancel |-> $onehot0(cancel_match))
    else $error("cancel uid matched more than one slot");

endmodule

`default_nettype wire

// ==== verilog/ob_qry_cnt.sv ====
// **************************************
// Depth query walker
// Steps from the head down to slot 1, one slot per cycle,
// summing quantity at or below a limit price
// Response is the sum and whether it covers the wanted quantity
// **************************************
`timescale 1ns/1ps
`default_nettype none

module ob_qry_cnt (
  input  logic               clk,
  input  logic               rst,
  input  logic               qry_vld,
  input  ob_pkg::price_t     qry_price,
  input  ob_pkg::quantity_t  qry_qty,
  input  ob_pkg::table_t     tbl,
  input  ob_pkg::slot_vec_t  tbl_vld,
  output logic               qry_busy,
  output logic               qry_rsp_vld,
  output logic               qry_rsp_ge,
  output ob_pkg::accum_qty_t qry_rsp_qty
);

  import ob_pkg::*;

  typedef enum logic [1:0] {
    QRY_IDLE,
    QRY_WALK,
    QRY_RSP
  } qry_state_t;

  qry_state_t state;

  // Walk context, latched on acceptance
  slot_idx_t  idx;
  price_t     lim_price;
  quantity_t  want_qty;
  accum_qty_t acc;

  logic       take;
  accum_qty_t acc_nxt;

  // Current slot counts when live and priced at or under the limit
  assign take    = tbl_vld[idx] && (tbl[idx].price <= lim_price);
  assign acc_nxt = take ? (acc + accum_qty_t'(tbl[idx].quantity)) : acc;

  // Busy through the walk and the response cycle
  assign qry_busy = (state != QRY_IDLE);

  // Control FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= QRY_IDLE;
      qry_rsp_vld <= 1'b0;
    end else begin
      qry_rsp_vld <= 1'b0;
      case (state)
        QRY_IDLE: if (qry_vld) state <= QRY_WALK;
        // Slot 1 is the last live slot and the reject is skipped
        QRY_WALK: if (idx == slot_idx_t'(1)) state <= QRY_RSP;
        QRY_RSP: begin
          state       <= QRY_IDLE;
          qry_rsp_vld <= 1'b1;
        end
        default: state <= QRY_IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    case (state)
      QRY_IDLE: begin
        if (qry_vld) begin
          lim_price <= qry_price;
          want_qty  <= qry_qty;
          idx       <= slot_idx_t'(TABLE_DEPTH);
          acc       <= '0;
        end
      end
      QRY_WALK: begin
        acc <= acc_nxt;
        idx <= idx - 1'b1;
      end
      // Response held until the next query completes
      QRY_RSP: begin
        qry_rsp_qty <= acc;
        qry_rsp_ge  <= (acc >= accum_qty_t'(want_qty));
      end
      default: ;
    endcase
  end

  // One query in flight at a time
  assert property (@(posedge clk) disable iff (rst)
    qry_vld |-> !qry_busy)
    else $error("query issued while walker busy");

  // Response pulse rises TABLE_DEPTH+1 edges after acceptance
  // and is first sampled one edge later
  assert property (@(posedge clk) disable iff (rst)
    qry_rsp_vld |-> $past(qry_vld && !qry_busy, TABLE_DEPTH + 2))
    else $error("query response not TABLE_DEPTH+1 cycles after acceptance");

endmodule

`default_nettype wire

// ==== verilog/ob_table.sv ====
// **************************************
// Ask-side order table top level
// Shift table core plus the depth query walker beside it
// Commands are single-cycle strobes, one per cycle
// **************************************
`timescale 1ns/1ps
`default_nettype none

module ob_table (
  input  logic               clk,
  input  logic               rst,
  input  logic               insert,
  input  ob_pkg::entry_t     insert_entry,
  input  logic               cancel,
  input  ob_pkg::uid_t       cancel_uid,
  input  logic               head_pop,
  input  logic               reject_pop,
  input  logic               qry_vld,
  input  ob_pkg::price_t     qry_price,
  input  ob_pkg::quantity_t  qry_qty,
  output logic               cancel_hit,
  output ob_pkg::entry_t     cancel_entry,
  output logic               head_vld,
  output ob_pkg::entry_t     head,
  output logic               reject_vld,
  output ob_pkg::entry_t     reject,
  output logic               qry_busy,
  output logic               qry_rsp_vld,
  output logic               qry_rsp_ge,
  output ob_pkg::accum_qty_t qry_rsp_qty
);

  import ob_pkg::*;

  // Registered table state shared with the walker
  table_t    tbl;
  slot_vec_t tbl_vld;

  ob_table_core u_core (
    .clk          (clk),
    .rst          (rst),
    .insert       (insert),
    .insert_entry (insert_entry),
    .cancel       (cancel),
    .cancel_uid   (cancel_uid),
    .head_pop     (head_pop),
    .reject_pop   (reject_pop),
    .cancel_hit   (cancel_hit),
    .cancel_entry (cancel_entry),
    .head_vld     (head_vld),
    .head         (head),
    .reject_vld   (reject_vld),
    .reject       (reject),
    .tbl          (tbl),
    .tbl_vld      (tbl_vld)
  );

  // Walker reads the table while it is held still
  ob_qry_cnt u_qry_cnt (
    .clk         (clk),
    .rst         (rst),
    .qry_vld     (qry_vld),
    .qry_price   (qry_price),
    .qry_qty     (qry_qty),
    .tbl         (tbl),
    .tbl_vld     (tbl_vld),
    .qry_busy    (qry_busy),
    .qry_rsp_vld (qry_rsp_vld),
    .qry_rsp_ge  (qry_rsp_ge),
    .qry_rsp_qty (qry_rsp_qty)
  );

endmodule

`default_nettype wire

// ==== include/ob_table_model.svh ====
// ****************************************
// Reference model of the ask-side order list
// Sorted queue with the head at index 0
// Last entry is the reject once the list overflows the live slots
// Included inside the testbench module after the package import
// ****************************************
`ifndef OB_TABLE_MODEL_SVH
`define OB_TABLE_MODEL_SVH

// Orders in price-time priority
ob_pkg::entry_t book_q[$];

// New entry goes behind every equal or lower price
function automatic void add_sorted(ob_pkg::entry_t e);
  int pos;
  pos = book_q.size();
  for (int i = book_q.size() - 1; i >= 0; i--) begin
    if (e.price < book_q[i].price) pos = i;
  end
  book_q.insert(pos, e);
endfunction

function automatic bit has_entries();
  return book_q.size() > 0;
endfunction

function automatic ob_pkg::entry_t first_entry();
  return (book_q.size() > 0) ? book_q[0] : ob_pkg::ENTRY_EMPTY;
endfunction

// Reject exists only once the list overflows the live slots
function automatic bit has_reject();
  return book_q.size() > ob_pkg::TABLE_DEPTH;
endfunction

function automatic ob_pkg::entry_t last_entry();
  return has_reject() ? book_q[ob_pkg::TABLE_DEPTH] : ob_pkg::ENTRY_EMPTY;
endfunction

function automatic void drop_first();
  if (book_q.size() > 0) book_q.delete(0);
endfunction

function automatic void drop_last();
  if (has_reject()) book_q.delete(book_q.size() - 1);
endfunction

// Takes out the entry with this uid and reports whether it was live
function automatic bit remove_uid(ob_pkg::uid_t uid, output ob_pkg::entry_t e);
  int pos;
  pos = -1;
  e   = '0;
  foreach (book_q[i]) begin
    if (pos < 0 && book_q[i].uid == uid) pos = i;
  end
  if (pos >= 0) begin
    e = book_q[pos];
    book_q.delete(pos);
  end
  return pos >= 0;
endfunction

// Sums live entries at or under the limit and skips the reject
function automatic ob_pkg::accum_qty_t depth_sum(ob_pkg::price_t limit);
  ob_pkg::accum_qty_t sum;
  sum = '0;
  for (int i = 0; i < book_q.size() && i < ob_pkg::TABLE_DEPTH; i++) begin
    if (book_q[i].price <= limit) sum += ob_pkg::accum_qty_t'(book_q[i].quantity);
  end
  return sum;
endfunction

`endif

// ==== verification/ob_table_tb.sv ====
// ****************************************
// Testbench for the ask-side order table
// Random legal commands run against a queue model, and
// concurrent assertions compare the DUT on every clock edge
// Stops at the first mismatch or at the cycle limit
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module ob_table_tb;

  import ob_pkg::*;

  // Sorted order list used as the reference
  `include "ob_table_model.svh"

  localparam int SEED           = 38689;
  localparam int NUM_OPS        = 300;
  localparam int TIMEOUT_CYCLES = 6000;
  // Edges from query launch to the sample that sees the response
  localparam int RSP_DELAY      = TABLE_DEPTH + 2;

  logic       clk;
  logic       rst;
  logic       insert;
  entry_t     insert_entry;
  logic       cancel;
  uid_t       cancel_uid;
  logic       head_pop;
  logic       reject_pop;
  logic       qry_vld;
  price_t     qry_price;
  quantity_t  qry_qty;
  logic       cancel_hit;
  entry_t     cancel_entry;
  logic       head_vld;
  entry_t     head;
  logic       reject_vld;
  entry_t     reject;
  logic       qry_busy;
  logic       qry_rsp_vld;
  logic       qry_rsp_ge;
  accum_qty_t qry_rsp_qty;

  // Expected state, moved on the same edge as the DUT registers
  logic       exp_head_vld;
  entry_t     exp_head;
  logic       exp_reject_vld;
  entry_t     exp_reject;
  logic       exp_cancel_hit;
  entry_t     exp_cancel_entry;
  accum_qty_t exp_rsp_qty;
  logic       exp_rsp_ge;
  int         rsp_cnt;
  int         cycles;
  uid_t       next_uid;

  ob_table DUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic abort_run(string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  // Mirror the model into the expected registers
  task automatic load_expected();
    exp_head_vld   <= has_entries();
    exp_head       <= first_entry();
    exp_reject_vld <= has_reject();
    exp_reject     <= last_entry();
  endtask

  // Drop all strobes one cycle after a command
  task automatic release_strobes();
    @(posedge clk);
    insert         <= 1'b0;
    cancel         <= 1'b0;
    head_pop       <= 1'b0;
    reject_pop     <= 1'b0;
    exp_cancel_hit <= 1'b0;
    load_expected();
  endtask

  task automatic place_order(entry_t e);
    @(posedge clk);
    insert       <= 1'b1;
    insert_entry <= e;
    add_sorted(e);
    release_strobes();
  endtask

  task automatic cancel_order(uid_t uid);
    entry_t e;
    logic   hit;
    @(posedge clk);
    cancel     <= 1'b1;
    cancel_uid <= uid;
    hit = remove_uid(uid, e);
    exp_cancel_hit   <= hit;
    exp_cancel_entry <= e;
    release_strobes();
  endtask

  task automatic pop_head();
    @(posedge clk);
    head_pop <= 1'b1;
    drop_first();
    release_strobes();
  endtask

  task automatic drain_reject();
    @(posedge clk);
    reject_pop <= 1'b1;
    drop_last();
    release_strobes();
  endtask

  // Launch a query and hold off until its response shows up
  task automatic run_query(price_t limit, quantity_t want);
    accum_qty_t sum;
    sum = depth_sum(limit);
    @(posedge clk);
    qry_vld     <= 1'b1;
    qry_price   <= limit;
    qry_qty     <= want;
    exp_rsp_qty <= sum;
    exp_rsp_ge  <= (sum >= accum_qty_t'(want));
    @(posedge clk);
    qry_vld <= 1'b0;
    @(negedge clk);
    while (!qry_rsp_vld) @(negedge clk);
  endtask

  // Narrow price band so ties are common
  // A pending reject is drained first
  task automatic add_random_order();
    entry_t e;
    if (has_reject()) drain_reject();
    e.uid      = next_uid;
    e.quantity = quantity_t'($urandom_range(1, 63));
    e.price    = price_t'(100 + $urandom_range(0, 7));
    next_uid   = next_uid + 1'b1;
    place_order(e);
  endtask

  // Picks a live uid half the time and an unused high uid otherwise
  task automatic cancel_random_uid();
    uid_t uid;
    if (book_q.size() > 0 && $urandom_range(0, 1) == 0) begin
      uid = book_q[$urandom_range(0, book_q.size() - 1)].uid;
    end else begin
      uid = uid_t'($urandom_range(200, 255));
    end
    cancel_order(uid);
  endtask

  always @(posedge clk) begin
    if (rst) begin
      rsp_cnt <= 0;
    end else if (qry_vld) begin
      rsp_cnt <= RSP_DELAY;
    end else if (rsp_cnt != 0) begin
      rsp_cnt <= rsp_cnt - 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) abort_run("timeout, run exceeded the cycle limit");
  end

  assert property (@(posedge clk) disable iff (rst) head_vld == exp_head_vld)
    else report_mismatch("head_vld", 32'($sampled(head_vld)),
                         32'($sampled(exp_head_vld)));
  assert property (@(posedge clk) disable iff (rst) exp_head_vld |-> head == exp_head)
    else report_mismatch("head", 32'($sampled(head)), 32'($sampled(exp_head)));
  assert property (@(posedge clk) disable iff (rst) reject_vld == exp_reject_vld)
    else report_mismatch("reject_vld", 32'($sampled(reject_vld)),
                         32'($sampled(exp_reject_vld)));
  assert property (@(posedge clk) disable iff (rst) exp_reject_vld |-> reject == exp_reject)
    else report_mismatch("reject", 32'($sampled(reject)), 32'($sampled(exp_reject)));
  assert property (@(posedge clk) disable iff (rst) cancel_hit == exp_cancel_hit)
    else report_mismatch("cancel_hit", 32'($sampled(cancel_hit)),
                         32'($sampled(exp_cancel_hit)));
  assert property (@(posedge clk) disable iff (rst)
    exp_cancel_hit |-> cancel_entry == exp_cancel_entry)
    else report_mismatch("cancel_entry", 32'($sampled(cancel_entry)),
                         32'($sampled(exp_cancel_entry)));
  // Busy and response timing follow the launch counter
  assert property (@(posedge clk) disable iff (rst) qry_busy == (rsp_cnt > 1))
    else report_mismatch("qry_busy", 32'($sampled(qry_busy)),
                         32'($sampled(rsp_cnt) > 1));
  assert property (@(posedge clk) disable iff (rst) qry_rsp_vld == (rsp_cnt == 1))
    else report_mismatch("qry_rsp_vld", 32'($sampled(qry_rsp_vld)),
                         32'($sampled(rsp_cnt) == 1));
  assert property (@(posedge clk) disable iff (rst) qry_rsp_vld |-> qry_rsp_qty == exp_rsp_qty)
    else report_mismatch("qry_rsp_qty", 32'($sampled(qry_rsp_qty)),
                         32'($sampled(exp_rsp_qty)));
  assert property (@(posedge clk) disable iff (rst) qry_rsp_vld |-> qry_rsp_ge == exp_rsp_ge)
    else report_mismatch("qry_rsp_ge", 32'($sampled(qry_rsp_ge)),
                         32'($sampled(exp_rsp_ge)));

  initial begin
    int sel;
    void'($urandom(SEED));
    rst              = 1'b1;
    insert           = 1'b0;
    insert_entry     = ENTRY_EMPTY;
    cancel           = 1'b0;
    cancel_uid       = '0;
    head_pop         = 1'b0;
    reject_pop       = 1'b0;
    qry_vld          = 1'b0;
    qry_price        = '0;
    qry_qty          = '0;
    exp_head_vld     = 1'b0;
    exp_head         = ENTRY_EMPTY;
    exp_reject_vld   = 1'b0;
    exp_reject       = ENTRY_EMPTY;
    exp_cancel_hit   = 1'b0;
    exp_cancel_entry = ENTRY_EMPTY;
    exp_rsp_qty      = '0;
    exp_rsp_ge       = 1'b0;
    cycles           = 0;
    next_uid         = uid_t'(1);
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // Overfill so the reject slot loads
    repeat (TABLE_DEPTH + 1) add_random_order();
    // Waiting reject re-enters after a cancel, then after a head pop
    cancel_order(book_q[2].uid);
    add_random_order();
    pop_head();
    add_random_order();
    drain_reject();
    run_query(price_t'(16'hfffe), quantity_t'(100));
    cancel_order(uid_t'(250));

    for (int n = 0; n < NUM_OPS; n++) begin
      sel = $urandom_range(0, 99);
      if (sel < 45) add_random_order();
      else if (sel < 65) cancel_random_uid();
      else if (sel < 77) pop_head();
      else if (sel < 85) drain_reject();
      else run_query(price_t'(99 + $urandom_range(0, 9)), quantity_t'($urandom_range(0, 255)));
    end

    repeat (4) @(posedge clk);
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
verilog/ob_pkg.sv
verilog/ob_table_core.sv
verilog/ob_qry_cnt.sv
verilog/ob_table.sv
verification/ob_table_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the order table testbench with Verilator and run it
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f \
  --top-module ob_table_tb \
  -o sim_ob_table &&
./obj_dir/sim_ob_table ||
{ echo "simulation failed"; exit 1; }
